// File: Bender.yml
package:
  name: panel_fill

sources:
  - include_dirs:
      - .
    files:
      - panel_pkg.sv
      - fill_area_walker.sv
      - cmd_fillrect.sv
      - frame_buffer.sv
      - panel_wb_slave.sv
      - panel_fill_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_panel_fill.sv

// File: cmd_fillrect.sv
//////////////////////////////////////////////////////////////////////
// Fill-rectangle command engine. Collects the command bytes, runs
// the area walker and pulses fill_done at the end of the command.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "panel_defs.svh"

module cmd_fillrect (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_valid,
    input  logic [7:0]           cmd_byte,
    output logic                 ready_for_data,
    output panel_pkg::fb_write_t fb_wr,
    output logic                 fill_done
);
    import panel_pkg::*;

    localparam int CNT_BITS = $clog2(`BYTES_PER_PIXEL + `COL_BYTES);
    localparam logic [CNT_BITS-1:0] COL_LAST = CNT_BITS'(`COL_BYTES - 1);
    localparam logic [CNT_BITS-1:0] PIX_LAST = CNT_BITS'(`BYTES_PER_PIXEL - 1);
    localparam col_addr_t COL_MAX = '1;
    localparam row_addr_t ROW_MAX = '1;

    typedef enum logic [2:0] {
        S_X1,
        S_Y1,
        S_WIDTH,
        S_HEIGHT,
        S_COLOR,
        S_START,
        S_RUN,
        S_DONE
    } state_t;

    state_t                  state;
    logic [CNT_BITS-1:0]     byte_cnt;   // Bytes left in the current field.
    logic [`COL_BYTES*8-1:0] x1_raw;
    logic [`COL_BYTES*8-1:0] width_raw;
    logic [7:0]              y1_raw;
    logic [7:0]              height_raw;
    pixel_t                  color;
    logic                    start;
    logic                    busy;
    logic                    take;
    fill_req_t               fill_req;

    assign ready_for_data = !(state inside {S_START, S_RUN});
    assign fill_done      = (state == S_DONE);
    assign take           = cmd_valid && ready_for_data;

    // Oversized extents saturate, an origin off the panel draws nothing.
    always_comb begin
        fill_req.x1     = col_addr_t'(x1_raw);
        fill_req.y1     = row_addr_t'(y1_raw);
        fill_req.width  = (width_raw > COL_MAX) ? COL_MAX : col_addr_t'(width_raw);
        fill_req.height = (height_raw > ROW_MAX) ? ROW_MAX : row_addr_t'(height_raw);
        fill_req.color  = color;
        if (x1_raw >= `PANEL_COLS || y1_raw >= `PANEL_ROWS) begin
            fill_req.width = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_X1;
            byte_cnt   <= COL_LAST;
            start      <= 1'b0;
            x1_raw     <= '0;
            width_raw  <= '0;
            y1_raw     <= '0;
            height_raw <= '0;
            color      <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                // DONE accepts the first byte of the next command.
                S_X1, S_DONE: begin
                    state <= S_X1;
                    if (take) begin
                        x1_raw[byte_cnt*8 +: 8] <= cmd_byte;    // MSB first.
                        if (byte_cnt == '0) begin
                            state    <= S_Y1;
                            byte_cnt <= COL_LAST;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                S_Y1: begin
                    if (take) begin
                        y1_raw <= cmd_byte;
                        state  <= S_WIDTH;
                    end
                end
                S_WIDTH: begin
                    if (take) begin
                        width_raw[byte_cnt*8 +: 8] <= cmd_byte;
                        if (byte_cnt == '0) begin
                            state    <= S_HEIGHT;
                            byte_cnt <= PIX_LAST;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                S_HEIGHT: begin
                    if (take) begin
                        height_raw <= cmd_byte;
                        state      <= S_COLOR;
                    end
                end
                S_COLOR: begin
                    if (take) begin
                        color[byte_cnt*8 +: 8] <= cmd_byte;
                        if (byte_cnt == '0) begin
                            state    <= S_START;
                            byte_cnt <= COL_LAST;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                S_START: begin
                    start <= 1'b1;
                    state <= S_RUN;
                end
                S_RUN: begin
                    // Busy is valid from the cycle after start.
                    if (!start && !busy) begin
                        state      <= S_DONE;
                        x1_raw     <= '0;
                        width_raw  <= '0;
                        y1_raw     <= '0;
                        height_raw <= '0;
                        color      <= '0;
                    end
                end
                default: state <= S_X1;
            endcase
        end
    end

    fill_area_walker walker_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .fill_req (fill_req),
        .busy     (busy),
        .fb_wr    (fb_wr)
    );

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

// File: fill_area_walker.sv
//////////////////////////////////////////////////////////////////////
// Area walker. Clips the rectangle to the panel and writes one pixel
// per clock, column first, then row.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "panel_defs.svh"

module fill_area_walker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  panel_pkg::fill_req_t fill_req,
    output logic                 busy,
    output panel_pkg::fb_write_t fb_wr
);
    import panel_pkg::*;

    typedef logic [`PANEL_COL_BITS:0] col_span_t;
    typedef logic [`PANEL_ROW_BITS:0] row_span_t;

    fill_req_t req_q;
    col_addr_t col;
    col_addr_t col_last;
    row_addr_t row;
    row_addr_t row_last;
    col_span_t col_room;
    col_span_t col_span;
    row_span_t row_room;
    row_span_t row_span;

    // Clipped extent, w' = min(width, cols - x1) and likewise for rows.
    always_comb begin
        col_room = col_span_t'(`PANEL_COLS) - {1'b0, fill_req.x1};
        col_span = ({1'b0, fill_req.width} < col_room) ? {1'b0, fill_req.width} : col_room;
        row_room = row_span_t'(`PANEL_ROWS) - {1'b0, fill_req.y1};
        row_span = ({1'b0, fill_req.height} < row_room) ? {1'b0, fill_req.height} : row_room;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= (col_span != '0) && (row_span != '0);
        end else if (busy && col == col_last && row == row_last) begin
            busy <= 1'b0;                                   // Last write issued.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q    <= fill_req;
            col      <= fill_req.x1;
            row      <= fill_req.y1;
            col_last <= fill_req.x1 + col_addr_t'(col_span - 1'b1);
            row_last <= fill_req.y1 + row_addr_t'(row_span - 1'b1);
        end else if (busy) begin
            if (col == col_last) begin
                col <= req_q.x1;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_comb begin
        fb_wr = '{we: busy, row: row, col: col, color: req_q.color};
    end

    // Writes stay in the requested rectangle, so nothing wraps past an edge.
    a_write_in_bounds: assert property (@(posedge clk) disable iff (reset)
        fb_wr.we |-> (fb_wr.col >= req_q.x1) && (fb_wr.row >= req_q.y1)
            && ({1'b0, fb_wr.col} < {1'b0, req_q.x1} + {1'b0, req_q.width})
            && ({1'b0, fb_wr.row} < {1'b0, req_q.y1} + {1'b0, req_q.height}));

endmodule

// File: frame_buffer.sv
//////////////////////////////////////////////////////////////////////
// Dual-port pixel RAM, one write port and one registered read port.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "panel_defs.svh"

module frame_buffer (
    input  logic                 clk,
    input  panel_pkg::fb_write_t wr,
    input  panel_pkg::row_addr_t rd_row,
    input  panel_pkg::col_addr_t rd_col,
    output panel_pkg::pixel_t    rd_pixel
);
    import panel_pkg::*;

    pixel_t mem [`PANEL_ROWS][`PANEL_COLS];   // Row major.

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.row][wr.col] <= wr.color;
        end
    end

    // Read during write returns the old pixel.
    always_ff @(posedge clk) begin
        rd_pixel <= mem[rd_row][rd_col];
    end

endmodule

// File: panel_defs.svh
//////////////////////////////////////////////////////////////////////
// Panel geometry, pixel size and Wishbone register map.
//////////////////////////////////////////////////////////////////////

`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// 64 x 32 panel.
`define PANEL_COL_BITS 6
`define PANEL_ROW_BITS 5
`define PANEL_COLS (1 << `PANEL_COL_BITS)
`define PANEL_ROWS (1 << `PANEL_ROW_BITS)

`define BYTES_PER_PIXEL 2                        // RGB565.
`define COL_BYTES ((`PANEL_COL_BITS + 7) / 8)    // Bytes per column field.

// Wishbone word address and register indexes.
`define WB_ADR_BITS 12
`define REG_CMD_DATA 0
`define REG_STATUS 1

`endif

// File: panel_fill_top.sv
//////////////////////////////////////////////////////////////////////
// Panel fill controller top, Wishbone slave, command engine, RAM.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module panel_fill_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  panel_pkg::wb_addr_u wb_adr,
    input  logic [31:0]         wb_dat_w,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack,
    output logic                fill_done
);
    import panel_pkg::*;

    logic       cmd_valid;
    logic [7:0] cmd_byte;
    logic       ready_for_data;
    fb_write_t  fb_wr;
    row_addr_t  rd_row;
    col_addr_t  rd_col;
    pixel_t     rd_pixel;

    panel_wb_slave wb_slave_i (
        .clk            (clk),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .cmd_valid      (cmd_valid),
        .cmd_byte       (cmd_byte),
        .ready_for_data (ready_for_data),
        .fill_done      (fill_done),
        .rd_row         (rd_row),
        .rd_col         (rd_col),
        .rd_pixel       (rd_pixel)
    );

    cmd_fillrect cmd_i (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_byte       (cmd_byte),
        .ready_for_data (ready_for_data),
        .fb_wr          (fb_wr),
        .fill_done      (fill_done)
    );

    frame_buffer fb_i (
        .clk      (clk),
        .wr       (fb_wr),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_pixel (rd_pixel)
    );

endmodule

// File: panel_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the panel fill controller.
//////////////////////////////////////////////////////////////////////

`include "panel_defs.svh"

package panel_pkg;

    typedef logic [`PANEL_COL_BITS-1:0] col_addr_t;          // Column, also width.
    typedef logic [`PANEL_ROW_BITS-1:0] row_addr_t;          // Row, also height.
    typedef logic [`BYTES_PER_PIXEL*8-1:0] pixel_t;

    typedef struct packed {
        col_addr_t x1;
        row_addr_t y1;
        col_addr_t width;
        row_addr_t height;
        pixel_t    color;
    } fill_req_t;

    typedef struct packed {
        logic      we;
        row_addr_t row;
        col_addr_t col;
        pixel_t    color;
    } fb_write_t;

    // Region bit 0 selects the register file, 1 the frame buffer.
    typedef struct packed {
        logic                    region;
        logic [`WB_ADR_BITS-2:0] idx;
    } wb_reg_view_t;

    typedef struct packed {
        logic      region;
        row_addr_t row;
        col_addr_t col;
    } wb_fb_view_t;

    typedef union packed {
        wb_reg_view_t reg_view;
        wb_fb_view_t  fb_view;
    } wb_addr_u;

endpackage

// File: panel_wb_slave.sv
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave for the command data, status register and
// frame-buffer readback.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_wb_slave (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  panel_pkg::wb_addr_u  wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    output logic                 cmd_valid,
    output logic [7:0]           cmd_byte,
    input  logic                 ready_for_data,
    input  logic                 fill_done,
    output panel_pkg::row_addr_t rd_row,
    output panel_pkg::col_addr_t rd_col,
    input  panel_pkg::pixel_t    rd_pixel
);
    import panel_pkg::*;

    logic        wb_req;
    logic        is_fb;
    logic        is_cmd;
    logic        is_status;
    logic        fb_rd_pend;   // RAM read in flight.
    logic        sticky_done;
    logic [31:0] status_word;

    // No new request while an ack or a RAM read is outstanding.
    assign wb_req    = wb_cyc && wb_stb && !wb_ack && !fb_rd_pend;
    assign is_fb     = wb_adr.fb_view.region;
    assign is_cmd    = !is_fb && (wb_adr.reg_view.idx == `REG_CMD_DATA);
    assign is_status = !is_fb && (wb_adr.reg_view.idx == `REG_STATUS);

    assign cmd_valid = wb_req && wb_we && is_cmd;
    assign cmd_byte  = wb_dat_w[7:0];
    assign rd_row    = wb_adr.fb_view.row;
    assign rd_col    = wb_adr.fb_view.col;

    assign status_word = {30'b0, sticky_done, !ready_for_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            fb_rd_pend  <= 1'b0;
            sticky_done <= 1'b0;
        end else begin
            wb_ack     <= 1'b0;
            fb_rd_pend <= 1'b0;
            if (fb_rd_pend) begin
                wb_ack <= 1'b1;
            end else if (wb_req) begin
                if (is_fb && !wb_we) begin
                    fb_rd_pend <= 1'b1;
                end else if (cmd_valid) begin
                    wb_ack <= ready_for_data;                // Held off while busy.
                end else begin
                    wb_ack <= 1'b1;
                end
            end
            if (fill_done) begin
                sticky_done <= 1'b1;                         // Set wins over clear.
            end else if (wb_req && !wb_we && is_status) begin
                sticky_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fb_rd_pend) begin
            wb_dat_r <= 32'(rd_pixel);
        end else if (wb_req && !wb_we && !is_fb) begin
            wb_dat_r <= is_status ? status_word : 32'b0;
        end
    end

    a_ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_cyc && wb_stb);

endmodule

// File: sources.f
+incdir+.
panel_pkg.sv
fill_area_walker.sv
cmd_fillrect.sv
frame_buffer.sv
panel_wb_slave.sv
panel_fill_top.sv
tb_panel_fill.sv

// File: tb_panel_fill.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the panel fill controller with a shadow pixel model.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "panel_defs.svh"

module tb_panel_fill;
    import panel_pkg::*;

    localparam int N_RAND     = 6;
    localparam int N_EDGE     = 4;
    localparam int N_CMDS     = 4 + N_RAND + N_EDGE + 2 + 2;
    localparam int N_READBACK = 4;
    localparam int PANEL_PIX  = `PANEL_COLS * `PANEL_ROWS;
    // Full-panel fill per command plus bytes, about 5 cycles per readback pixel, margin 2.
    localparam int MAX_CYCLES =
        2 * (N_CMDS * (PANEL_PIX + 40) + N_READBACK * PANEL_PIX * 5 + 100);

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_u    wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        fill_done;

    pixel_t shadow [`PANEL_ROWS][`PANEL_COLS];   // Expected frame buffer.
    int     errors;
    int     done_cnt;
    int     cmds_sent;
    int     cycles;

    panel_fill_top dut_i (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (!reset && fill_done) begin
            done_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, a transfer or a fill never finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) fill_done |=> !fill_done)
        else begin
            errors++;
            $display("fill_done stayed high for more than one cycle");
        end

    a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !wb_ack && !fill_done)
        else begin
            errors++;
            $display("wb_ack or fill_done was high right after reset");
        end

    function automatic wb_addr_u reg_addr(input int idx);
        wb_addr_u a;
        a.reg_view.region = 1'b0;
        a.reg_view.idx    = idx[`WB_ADR_BITS-2:0];
        return a;
    endfunction

    function automatic wb_addr_u fb_addr(input int row, input int col);
        wb_addr_u a;
        a.fb_view.region = 1'b1;
        a.fb_view.row    = row[`PANEL_ROW_BITS-1:0];
        a.fb_view.col    = col[`PANEL_COL_BITS-1:0];
        return a;
    endfunction

    task automatic wb_write(input wb_addr_u adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_addr_u adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic check_status(input string name, input logic [31:0] mask,
                                input logic [31:0] exp);
        logic [31:0] data;
        wb_read(reg_addr(`REG_STATUS), data);
        a_status: assert ((data & mask) == exp) else begin
            errors++;
            $display("error: %s expected %h actual %h", name, exp, data & mask);
        end
    endtask

    task automatic send_cmd(input int x1, input int y1, input int w, input int h,
                            input pixel_t color);
        wb_write(reg_addr(`REG_CMD_DATA), 32'(x1));
        // The first byte is held off until every earlier command is done.
        a_backpressure: assert (done_cnt == cmds_sent) else begin
            errors++;
            $display("error: fill_done count at first byte expected %0d actual %0d",
                     cmds_sent, done_cnt);
        end
        wb_write(reg_addr(`REG_CMD_DATA), 32'(y1));
        wb_write(reg_addr(`REG_CMD_DATA), 32'(w));
        wb_write(reg_addr(`REG_CMD_DATA), 32'(h));
        wb_write(reg_addr(`REG_CMD_DATA), {24'b0, color[15:8]});
        wb_write(reg_addr(`REG_CMD_DATA), {24'b0, color[7:0]});
        cmds_sent++;
    endtask

    // Clipped extent is min(width, cols - x1) by min(height, rows - y1).
    task automatic model_fill(input int x1, input int y1, input int w, input int h,
                              input pixel_t color);
        int wc;
        int hc;
        wc = (w < `PANEL_COLS - x1) ? w : `PANEL_COLS - x1;
        hc = (h < `PANEL_ROWS - y1) ? h : `PANEL_ROWS - y1;
        for (int r = y1; r < y1 + hc; r++) begin
            for (int c = x1; c < x1 + wc; c++) begin
                shadow[r][c] = color;
            end
        end
    endtask

    task automatic run_cmd(input int x1, input int y1, input int w, input int h,
                           input pixel_t color);
        send_cmd(x1, y1, w, h, color);
        model_fill(x1, y1, w, h, color);
        while (done_cnt < cmds_sent) begin
            @(negedge clk);
        end
        a_one_done: assert (done_cnt == cmds_sent) else begin
            errors++;
            $display("error: fill_done count expected %0d actual %0d", cmds_sent, done_cnt);
        end
        check_status("sticky_done after fill", '1, 32'h2);
        check_status("sticky_done cleared", '1, 32'h0);
    endtask

    task automatic check_panel(input string name);
        logic [31:0] data;
        for (int r = 0; r < `PANEL_ROWS; r++) begin
            for (int c = 0; c < `PANEL_COLS; c++) begin
                wb_read(fb_addr(r, c), data);
                a_pixel: assert (data == 32'(shadow[r][c])) else begin
                    errors++;
                    $display("error: %s at (%0d,%0d) expected %h actual %h",
                             name, r, c, 32'(shadow[r][c]), data);
                end
            end
        end
    endtask

    initial begin
        int          x1;
        int          y1;
        int          w;
        int          h;
        pixel_t      color;
        clk       = 1'b0;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        errors    = 0;
        done_cnt  = 0;
        cmds_sent = 0;
        cycles    = 0;
        void'($urandom(32'hc9c8));
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        check_status("status after reset", '1, 32'h0);
        a_no_early_done: assert (done_cnt == 0) else begin
            errors++;
            $display("error: fill_done after reset expected 0 actual %0d", done_cnt);
        end

        // Whole panel from four clipped 63 x 31 fills.
        color = pixel_t'($urandom);
        for (int i = 0; i < 4; i++) begin
            run_cmd(i % 2, i / 2, 63, 31, color);
        end
        for (int i = 0; i < N_RAND; i++) begin
            x1 = $urandom % `PANEL_COLS;
            y1 = $urandom % `PANEL_ROWS;
            w  = 1 + $urandom % (`PANEL_COLS - x1);
            h  = 1 + $urandom % (`PANEL_ROWS - y1);
            w  = (w > 63) ? 63 : w;
            h  = (h > 31) ? 31 : h;
            run_cmd(x1, y1, w, h, pixel_t'($urandom));
        end
        check_panel("random fills");

        for (int i = 0; i < N_EDGE; i++) begin
            x1 = 48 + $urandom % 16;                        // Past the right edge.
            y1 = 20 + $urandom % 12;                        // Past the bottom edge.
            run_cmd(x1, y1, 17 + $urandom % 47, 13 + $urandom % 19, pixel_t'($urandom));
        end
        check_panel("clipped fills");

        run_cmd(5, 5, 0, 10, 16'hffff);
        run_cmd(5, 5, 10, 0, 16'hffff);
        check_panel("zero size fills");

        // Next command's first byte goes out while the long fill runs.
        color = pixel_t'($urandom);
        send_cmd(0, 0, 63, 31, color);
        model_fill(0, 0, 63, 31, color);
        check_status("busy during fill", 32'h1, 32'h1);
        run_cmd(10, 3, 20, 9, pixel_t'($urandom));
        check_panel("fills after back-pressure");

        repeat (4) @(posedge clk);
        a_done_count: assert (done_cnt == cmds_sent) else begin
            errors++;
            $display("error: final fill_done count expected %0d actual %0d",
                     cmds_sent, done_cnt);
        end
        $display("commands: %0d, errors: %0d", cmds_sent, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
